//--- compile.f
logic/abj_pkg.sv
logic/control_unit.sv
logic/register_file.sv
logic/decode_stage.sv
logic/decode_registers.sv
logic/execute_stage.sv
logic/abj_core_top.sv
tests/abj_core_tb.sv

//--- logic/abj_core_top.sv
`timescale 1ns/10ps
`default_nettype none

module abj_core_top (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           in_valid,
  input  abj_pkg::instr_t                in_instr,
  input  logic [abj_pkg::WORD_WIDTH-1:0] in_pc,
  output logic                           in_ready,
  output abj_pkg::wb_t                   res
);

  abj_pkg::dec_bundle_t                dec_bundle;
  abj_pkg::dec_bundle_t                held_bundle;
  abj_pkg::wb_t                        wb;
  logic                                stall;
  logic [abj_pkg::REG_INDEX_WIDTH-1:0] rd_a_idx;
  logic [abj_pkg::REG_INDEX_WIDTH-1:0] rd_b_idx;
  logic [abj_pkg::WORD_WIDTH-1:0]      rd_a_data;
  logic [abj_pkg::WORD_WIDTH-1:0]      rd_b_data;

  // Caller holds its instruction while a hazard is pending
  assign in_ready = ~stall;
  // Result port is the writeback register itself
  assign res = wb;

  decode_stage u_decode_stage (
    .in_valid  (in_valid),
    .in_instr  (in_instr),
    .in_pc     (in_pc),
    .held      (held_bundle),
    .rd_a_idx  (rd_a_idx),
    .rd_b_idx  (rd_b_idx),
    .rd_a_data (rd_a_data),
    .rd_b_data (rd_b_data),
    .bundle    (dec_bundle),
    .stall     (stall)
  );

  // Write port fed from writeback
  register_file u_register_file (
    .clk       (clk),
    .rst_n     (rst_n),
    .rd_a_idx  (rd_a_idx),
    .rd_b_idx  (rd_b_idx),
    .rd_a_data (rd_a_data),
    .rd_b_data (rd_b_data),
    .wb        (wb)
  );

  decode_registers u_decode_registers (
    .clk        (clk),
    .rst_n      (rst_n),
    .stall      (stall),
    .bundle_in  (dec_bundle),
    .bundle_out (held_bundle)
  );

  execute_stage u_execute_stage (
    .clk    (clk),
    .rst_n  (rst_n),
    .bundle (held_bundle),
    .wb     (wb)
  );

endmodule

`default_nettype wire

//--- logic/abj_pkg.sv
`default_nettype none

package abj_pkg;

  // Datapath, pc and instruction width
  localparam int WORD_WIDTH = 32;
  // Register index width, 32 architectural registers
  localparam int REG_INDEX_WIDTH = 5;
  // Immediate and memory offset field width
  localparam int OFFSET_SIZE = 15;

  // Major opcodes, top 7 bits of every instruction
  typedef enum logic [6:0] {
    OP_NOP  = 7'h00,
    OP_ALU  = 7'h01,
    OP_ADDI = 7'h02,
    OP_LW   = 7'h03,
    OP_SW   = 7'h04,
    OP_BEQ  = 7'h05
  } opcode_e;

  // Function codes for register-register ALU operations
  typedef enum logic [9:0] {
    FN_ADD = 10'd0,
    FN_SUB = 10'd1,
    FN_AND = 10'd2,
    FN_OR  = 10'd3,
    FN_XOR = 10'd4
  } funct_e;

  // ALU operation class chosen by the control unit
  typedef enum logic [1:0] {
    ALU_ADD   = 2'd0,
    ALU_SUB   = 2'd1,
    // Operation comes from the funct field
    ALU_FUNCT = 2'd2
  } alu_op_e;

  // Register format
  typedef struct packed {
    opcode_e                    opcode;
    logic [REG_INDEX_WIDTH-1:0] dst;
    logic [REG_INDEX_WIDTH-1:0] src1;
    logic [REG_INDEX_WIDTH-1:0] src2;
    funct_e                     funct;
  } r_fmt_t;

  // Immediate and memory format
  // For SW and BEQ the dst field names the second source register
  typedef struct packed {
    opcode_e                        opcode;
    logic [REG_INDEX_WIDTH-1:0]     dst;
    logic [REG_INDEX_WIDTH-1:0]     src1;
    logic signed [OFFSET_SIZE-1:0]  offset;
  } m_fmt_t;

  // One instruction word, two views with the opcode in the same place
  typedef union packed {
    r_fmt_t r;
    m_fmt_t m;
  } instr_t;

  // Control word, 9 bits
  typedef struct packed {
    logic    branch;
    logic    reg_write;
    logic    mem_read;
    logic    mem_to_reg;
    alu_op_e alu_op;
    logic    mem_write;
    logic    alu_src;
    logic    is_imm;
  } ctrl_t;

  // Decode result handed to the decode/execute register
  typedef struct packed {
    logic                       valid;
    logic [WORD_WIDTH-1:0]      pc;
    instr_t                     instr;
    ctrl_t                      ctrl;
    logic [REG_INDEX_WIDTH-1:0] dst;
    logic [REG_INDEX_WIDTH-1:0] src_a;
    logic [REG_INDEX_WIDTH-1:0] src_b;
    logic [WORD_WIDTH-1:0]      op_a;
    logic [WORD_WIDTH-1:0]      op_b;
    // Offset already sign-extended to word width
    logic [WORD_WIDTH-1:0]      offset;
  } dec_bundle_t;

  // Execute result, also the register file write request
  typedef struct packed {
    logic                       valid;
    logic [WORD_WIDTH-1:0]      pc;
    logic [REG_INDEX_WIDTH-1:0] dst;
    // ALU result, or the address for loads and stores
    logic [WORD_WIDTH-1:0]      value;
    logic                       reg_write;
    logic                       mem_read;
    logic                       mem_write;
    logic                       branch_taken;
    // Store data, op_b of a store
    logic [WORD_WIDTH-1:0]      store_data;
  } wb_t;

endpackage

`default_nettype wire

//--- logic/control_unit.sv
`timescale 1ns/10ps
`default_nettype none

module control_unit (
  input  abj_pkg::opcode_e opcode,
  output abj_pkg::ctrl_t   ctrl,
  output logic             reads_b
);

  always_comb
  begin
    // Default word is a NOP, also for unknown opcodes
    ctrl    = '0;
    reads_b = 1'b0;
    case (opcode)
      abj_pkg::OP_ALU:
      begin
        // Register-register, operation from funct
        ctrl.reg_write = 1'b1;
        ctrl.alu_op    = abj_pkg::ALU_FUNCT;
        reads_b        = 1'b1;
      end
      abj_pkg::OP_ADDI:
      begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_op    = abj_pkg::ALU_ADD;
        ctrl.alu_src   = 1'b1;
        ctrl.is_imm    = 1'b1;
      end
      abj_pkg::OP_LW:
      begin
        // Address is base plus offset
        ctrl.reg_write  = 1'b1;
        ctrl.mem_read   = 1'b1;
        ctrl.mem_to_reg = 1'b1;
        ctrl.alu_op     = abj_pkg::ALU_ADD;
        ctrl.alu_src    = 1'b1;
      end
      abj_pkg::OP_SW:
      begin
        // No register write, dst field holds the data register
        ctrl.mem_write = 1'b1;
        ctrl.alu_op    = abj_pkg::ALU_ADD;
        ctrl.alu_src   = 1'b1;
        reads_b        = 1'b1;
      end
      abj_pkg::OP_BEQ:
      begin
        // Compare by subtraction, zero means equal
        ctrl.branch = 1'b1;
        ctrl.alu_op = abj_pkg::ALU_SUB;
        reads_b     = 1'b1;
      end
      default:
      begin
        ctrl    = '0;
        reads_b = 1'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- logic/decode_registers.sv
`timescale 1ns/10ps
`default_nettype none

module decode_registers (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 stall,
  input  abj_pkg::dec_bundle_t bundle_in,
  output abj_pkg::dec_bundle_t bundle_out
);

  // Decode/execute boundary
  // Whole bundle moves forward every cycle
  always_ff @(posedge clk)
  begin
    // Payload follows decode on every edge
    bundle_out <= bundle_in;
    if (!rst_n)
    begin
      // Empty pipe out of reset
      bundle_out.valid <= 1'b0;
      bundle_out.ctrl  <= '0;
    end
    else if (stall)
    begin
      // Bubble while the consumer waits in decode
      // Control cleared so the bubble cannot raise a hazard or a write
      bundle_out.valid <= 1'b0;
      bundle_out.ctrl  <= '0;
    end
  end

endmodule

`default_nettype wire

//--- logic/decode_stage.sv
`timescale 1ns/10ps
`default_nettype none

module decode_stage (
  input  logic                                 in_valid,
  input  abj_pkg::instr_t                      in_instr,
  input  logic [abj_pkg::WORD_WIDTH-1:0]       in_pc,
  input  abj_pkg::dec_bundle_t                 held,
  output logic [abj_pkg::REG_INDEX_WIDTH-1:0]  rd_a_idx,
  output logic [abj_pkg::REG_INDEX_WIDTH-1:0]  rd_b_idx,
  input  logic [abj_pkg::WORD_WIDTH-1:0]       rd_a_data,
  input  logic [abj_pkg::WORD_WIDTH-1:0]       rd_b_data,
  output abj_pkg::dec_bundle_t                 bundle,
  output logic                                 stall
);

  abj_pkg::ctrl_t                      ctrl_raw;
  logic                                reads_b;
  logic                                reads_a;
  logic [abj_pkg::REG_INDEX_WIDTH-1:0] src_a;
  logic [abj_pkg::REG_INDEX_WIDTH-1:0] src_b;
  logic                                hit_a;
  logic                                hit_b;
  logic                                producer;

  control_unit u_control_unit (
    .opcode  (in_instr.r.opcode),
    .ctrl    (ctrl_raw),
    .reads_b (reads_b)
  );

  // First source sits at the same place in both formats
  assign src_a = in_instr.m.src1;
  // Second source is src2 for register ops and the dst field for SW and BEQ
  assign src_b = (in_instr.r.opcode == abj_pkg::OP_ALU) ? in_instr.r.src2 : in_instr.m.dst;

  assign rd_a_idx = src_a;
  assign rd_b_idx = src_b;

  // Every real opcode reads src1
  // NOP has an all-zero control word
  assign reads_a = |ctrl_raw;

  // Held instruction will write a live register
  assign producer = held.valid && held.ctrl.reg_write && (held.dst != '0);

  // RAW match on each source that is actually read
  assign hit_a = reads_a && (src_a == held.dst);
  assign hit_b = reads_b && (src_b == held.dst);

  // One bubble lets the write-through supply the value
  assign stall = in_valid && producer && (hit_a || hit_b);

  always_comb
  begin
    bundle.valid = in_valid;
    bundle.pc    = in_pc;
    bundle.instr = in_instr;
    // Idle slots carry no control
    bundle.ctrl  = in_valid ? ctrl_raw : '0;
    bundle.dst   = in_instr.m.dst;
    bundle.src_a = src_a;
    bundle.src_b = src_b;
    bundle.op_a  = rd_a_data;
    bundle.op_b  = rd_b_data;
    // Sign extension of the 15-bit offset
    bundle.offset = {
      {(abj_pkg::WORD_WIDTH - abj_pkg::OFFSET_SIZE){in_instr.m.offset[abj_pkg::OFFSET_SIZE-1]}},
      in_instr.m.offset
    };
  end

endmodule

`default_nettype wire

//--- logic/execute_stage.sv
`timescale 1ns/10ps
`default_nettype none

module execute_stage (
  input  logic                 clk,
  input  logic                 rst_n,
  input  abj_pkg::dec_bundle_t bundle,
  output abj_pkg::wb_t         wb
);

  logic [abj_pkg::WORD_WIDTH-1:0] operand_b;
  logic [abj_pkg::WORD_WIDTH-1:0] funct_result;
  logic [abj_pkg::WORD_WIDTH-1:0] alu_result;
  logic                           branch_taken;

  // Offset for immediates and addresses, otherwise op_b
  assign operand_b = bundle.ctrl.alu_src ? bundle.offset : bundle.op_b;

  // Register-register operations decoded from funct
  always_comb
  begin
    case (bundle.instr.r.funct)
      abj_pkg::FN_ADD: funct_result = bundle.op_a + operand_b;
      abj_pkg::FN_SUB: funct_result = bundle.op_a - operand_b;
      abj_pkg::FN_AND: funct_result = bundle.op_a & operand_b;
      abj_pkg::FN_OR:  funct_result = bundle.op_a | operand_b;
      abj_pkg::FN_XOR: funct_result = bundle.op_a ^ operand_b;
      // Undefined funct gives zero
      default:         funct_result = '0;
    endcase
  end

  always_comb
  begin
    case (bundle.ctrl.alu_op)
      abj_pkg::ALU_ADD:   alu_result = bundle.op_a + operand_b;
      abj_pkg::ALU_SUB:   alu_result = bundle.op_a - operand_b;
      abj_pkg::ALU_FUNCT: alu_result = funct_result;
      default:            alu_result = '0;
    endcase
  end

  // BEQ subtracts, equal operands give zero
  assign branch_taken = bundle.ctrl.branch && (alu_result == '0);

  // Execute/writeback register
  always_ff @(posedge clk)
  begin
    wb.pc         <= bundle.pc;
    wb.dst        <= bundle.dst;
    wb.value      <= alu_result;
    wb.store_data <= bundle.op_b;
    if (!rst_n)
    begin
      wb.valid        <= 1'b0;
      wb.reg_write    <= 1'b0;
      wb.mem_read     <= 1'b0;
      wb.mem_write    <= 1'b0;
      wb.branch_taken <= 1'b0;
    end
    else
    begin
      wb.valid        <= bundle.valid;
      wb.reg_write    <= bundle.ctrl.reg_write;
      wb.mem_read     <= bundle.ctrl.mem_read;
      wb.mem_write    <= bundle.ctrl.mem_write;
      wb.branch_taken <= branch_taken;
    end
  end

endmodule

`default_nettype wire

//--- logic/register_file.sv
`timescale 1ns/10ps
`default_nettype none

module register_file (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic [abj_pkg::REG_INDEX_WIDTH-1:0]  rd_a_idx,
  input  logic [abj_pkg::REG_INDEX_WIDTH-1:0]  rd_b_idx,
  output logic [abj_pkg::WORD_WIDTH-1:0]       rd_a_data,
  output logic [abj_pkg::WORD_WIDTH-1:0]       rd_b_data,
  input  abj_pkg::wb_t                         wb
);

  // Registers 1 to 31, register 0 has no storage
  logic [abj_pkg::WORD_WIDTH-1:0] regs [1:31];
  logic                           wr_en;

  // Writes to register 0 are dropped here
  assign wr_en = wb.valid && wb.reg_write && (wb.dst != '0);

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      for (int i = 1; i < 32; i++)
      begin
        regs[i] <= '0;
      end
    end
    else if (wr_en)
    begin
      regs[wb.dst] <= wb.value;
    end
  end

  // Read port A
  // Same-cycle write is passed straight through
  always_comb
  begin
    if (rd_a_idx == '0)
      rd_a_data = '0;
    else if (wr_en && (wb.dst == rd_a_idx))
      rd_a_data = wb.value;
    else
      rd_a_data = regs[rd_a_idx];
  end

  // Read port B, same rules
  always_comb
  begin
    if (rd_b_idx == '0)
      rd_b_data = '0;
    else if (wr_en && (wb.dst == rd_b_idx))
      rd_b_data = wb.value;
    else
      rd_b_data = regs[rd_b_idx];
  end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, exit status is the verdict
set -e
cd "$(dirname "$0")"
verilator --binary --timing --top-module abj_core_tb -f compile.f \
  --Mdir obj_dir -o abj_core_sim
./obj_dir/abj_core_sim

//--- tests/abj_core_tb.sv
`timescale 1ns/10ps
`default_nettype none

module abj_core_tb;

  logic                           clk;
  logic                           rst_n;
  logic                           in_valid;
  abj_pkg::instr_t                in_instr;
  logic [abj_pkg::WORD_WIDTH-1:0] in_pc;
  logic                           in_ready;
  abj_pkg::wb_t                   res;

  // Stimulus and expected results from the data file
  logic [31:0]  instr_q [$];
  logic [31:0]  pc_q [$];
  abj_pkg::wb_t exp_q [$];
  abj_pkg::wb_t exp_head;
  // Architectural register values built from the expected writes
  logic [31:0]  reg_model [32];
  int           stall_expect;
  int           stall_cycles;
  int           cycle_count;
  int           cycle_limit;

  abj_core_top u_abj_core_top (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (in_valid),
    .in_instr (in_instr),
    .in_pc    (in_pc),
    .in_ready (in_ready),
    .res      (res)
  );

  // 20 ns clock
  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Something failed");
    $fatal(1, "Run stopped at first error");
  endtask

  task automatic compare_field(input string name, input logic [31:0] exp_val,
                               input logic [31:0] act_val);
    if (exp_val !== act_val)
      fail_run($sformatf("CHECK FAILED time=%0t field=%s expected=%h actual=%h",
                         $time, name, exp_val, act_val));
  endtask

  // One writeback result against its expected entry
  task automatic check_wb(input abj_pkg::wb_t exp_wb, input abj_pkg::wb_t act_wb);
    compare_field("res.pc", exp_wb.pc, act_wb.pc);
    compare_field("res.dst", 32'(exp_wb.dst), 32'(act_wb.dst));
    compare_field("res.value", exp_wb.value, act_wb.value);
    compare_field("res.reg_write", 32'(exp_wb.reg_write), 32'(act_wb.reg_write));
    compare_field("res.mem_read", 32'(exp_wb.mem_read), 32'(act_wb.mem_read));
    compare_field("res.mem_write", 32'(exp_wb.mem_write), 32'(act_wb.mem_write));
    compare_field("res.branch_taken", 32'(exp_wb.branch_taken), 32'(act_wb.branch_taken));
    // Store data only has a meaning for stores
    if (exp_wb.mem_write)
      compare_field("res.store_data", exp_wb.store_data, act_wb.store_data);
  endtask

  task automatic check_stalls(input int exp_count, input int act_count);
    compare_field("stall_cycles", 32'(exp_count), 32'(act_count));
  endtask

  // Parse I, E and S lines and skip comment lines
  task automatic read_testdata;
    int                fd;
    int                code;
    logic [7:0]        tag;
    logic [31:0]       f_a;
    logic [31:0]       f_b;
    logic [31:0]       f_c;
    logic [31:0]       f_rw;
    logic [31:0]       f_mr;
    logic [31:0]       f_mw;
    logic [31:0]       f_bt;
    logic [8*256-1:0]  line_buf;
    abj_pkg::wb_t      entry;
    // All registers read zero out of reset
    for (int r = 0; r < 32; r++)
    begin
      reg_model[r] = '0;
    end
    fd = $fopen("tests/abj_core_testdata.txt", "r");
    if (fd == 0)
      fail_run("Cannot open the test data file tests/abj_core_testdata.txt");
    code = $fscanf(fd, " %c", tag);
    while (code == 1)
    begin
      if (tag == "#")
        code = $fgets(line_buf, fd);
      else if (tag == "I")
      begin
        code = $fscanf(fd, "%h %h", f_a, f_b);
        if (code != 2)
          fail_run("Malformed instruction line in the test data file");
        instr_q.push_back(f_a);
        pc_q.push_back(f_b);
      end
      else if (tag == "E")
      begin
        code = $fscanf(fd, "%h %d %h %d %d %d %d", f_a, f_b, f_c, f_rw, f_mr, f_mw, f_bt);
        if (code != 7)
          fail_run("Malformed expected-result line in the test data file");
        entry              = '0;
        entry.valid        = 1'b1;
        entry.pc           = f_a;
        entry.dst          = f_b[abj_pkg::REG_INDEX_WIDTH-1:0];
        entry.value        = f_c;
        entry.reg_write    = f_rw[0];
        entry.mem_read     = f_mr[0];
        entry.mem_write    = f_mw[0];
        entry.branch_taken = f_bt[0];
        // A store carries the register named by its dst field
        if (entry.mem_write)
          entry.store_data = reg_model[entry.dst];
        // Model follows the writes in program order
        if (entry.reg_write && (entry.dst != '0))
          reg_model[entry.dst] = entry.value;
        exp_q.push_back(entry);
      end
      else if (tag == "S")
      begin
        code = $fscanf(fd, "%d", stall_expect);
        if (code != 1)
          fail_run("Malformed stall-count line in the test data file");
      end
      else
        fail_run("Unknown line tag in the test data file");
      code = $fscanf(fd, " %c", tag);
    end
    $fclose(fd);
  endtask

  // Present one instruction and hold it until accepted
  task automatic drive_instr(input logic [31:0] word, input logic [31:0] pc);
    in_valid = 1'b1;
    in_instr = word;
    in_pc    = pc;
    @(negedge clk);
    while (!in_ready)
    begin
      stall_cycles++;
      @(negedge clk);
    end
    // Accepted on this edge
    @(posedge clk);
    #2;
  endtask

  // Watchdog on a cycle limit set from the stimulus length
  always @(posedge clk)
  begin
    cycle_count = cycle_count + 1;
    if (cycle_count > cycle_limit)
      fail_run("Timeout, the run did not finish within the cycle limit");
  end

  // Scoreboard compares results in acceptance order
  always @(negedge clk)
  begin
    if (rst_n && res.valid)
    begin
      if (exp_q.size() == 0)
        fail_run("Extra result with no expected entry left");
      else
      begin
        exp_head = exp_q.pop_front();
        check_wb(exp_head, res);
      end
    end
  end

  initial
  begin
    rst_n        = 1'b0;
    in_valid     = 1'b0;
    in_instr     = '0;
    in_pc        = '0;
    stall_expect = 0;
    stall_cycles = 0;
    cycle_count  = 0;
    cycle_limit  = 1000;
    read_testdata();
    // Limit covers reset, three cycles per instruction and a margin
    cycle_limit = 10 + 3 * instr_q.size() + 50;
    repeat (10) @(posedge clk);
    #2;
    rst_n = 1'b1;
    // Idle cycles where no result may appear
    repeat (3) @(posedge clk);
    #2;
    for (int i = 0; i < instr_q.size(); i++)
    begin
      drive_instr(instr_q[i], pc_q[i]);
    end
    in_valid = 1'b0;
    in_instr = '0;
    // Last result trails its acceptance by two cycles
    // Two more edges leave room for a stray result
    repeat (4) @(posedge clk);
    #2;
    check_stalls(stall_expect, stall_cycles);
    if (exp_q.size() != 0)
      fail_run($sformatf("Missing results, %0d expected entries never arrived", exp_q.size()));
    else
    begin
      $display("Everything OK");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- tests/abj_core_testdata.txt
# I <instruction hex> <pc hex>
# E <pc hex> <dst dec> <value hex> <reg_write> <mem_read> <mem_write> <branch_taken>, S <stall cycles>
I 04148007 00000100
E 00000100 1 00000007 1 0 0 0
I 04207FFD 00000104
E 00000104 2 FFFFFFFD 1 0 0 0
I 04303FFF 00000108
E 00000108 3 00003FFF 1 0 0 0
I 04404000 0000010C
E 0000010C 4 FFFFC000 1 0 0 0
I 02508800 00000110
E 00000110 5 00000004 1 0 0 0
I 02608C01 00000114
E 00000114 6 FFFFC008 1 0 0 0
I 02711002 00000118
E 00000118 7 FFFFC000 1 0 0 0
I 02808C03 0000011C
E 0000011C 8 00003FFF 1 0 0 0
I 02910C04 00000120
E 00000120 9 FFFFC002 1 0 0 0
I 02008400 00000124
E 00000124 0 0000000E 1 0 0 0
I 04A00001 00000128
E 00000128 10 00000001 1 0 0 0
I 04B50002 0000012C
E 0000012C 11 00000003 1 0 0 0
I 02C52C00 00000130
E 00000130 12 00000004 1 0 0 0
I 08508008 00000134
E 00000134 5 0000000F 0 0 1 0
I 04D28000 00000138
E 00000138 13 00000004 1 0 0 0
I 06E20020 0000013C
E 0000013C 14 FFFFC020 1 1 0 0
I 06F0FFFC 00000140
E 00000140 15 00000003 1 1 0 0
I 0AD28000 00000144
E 00000144 13 00000000 0 0 0 1
I 0A208000 00000148
E 00000148 2 0000000A 0 0 0 0
I 05078005 0000014C
E 0000014C 16 00000008 1 0 0 0
I 03184000 00000150
E 00000150 17 00000010 1 0 0 0
S 3
